//--- rtl/rename_types.sv
package rename_types;

    localparam int PHYS_REG_W = 6;

    // physical register index into the 64-entry pool
    typedef logic [PHYS_REG_W-1:0] phys_reg_t;

    // reset-time layout of the register pool
    localparam int NUM_ARCH_REGS = 32;   // identity mapped at reset
    localparam int NUM_PHYS_REGS = 64;

    // registers left over for renaming, start in the free list
    localparam int NUM_FREE_REGS = NUM_PHYS_REGS - NUM_ARCH_REGS;

endpackage : rename_types

//--- rtl/rv32i_types.sv
package rv32i_types;

    // architectural register index, x0..x31
    localparam int ARCH_REG_W = 5;

    typedef logic [ARCH_REG_W-1:0] arch_reg_t;

    // commit record handed from the rob to the retirement map
    // phys_reg holds the new mapping, arch_reg the destination
    typedef struct packed {
        rename_types::phys_reg_t phys_reg;
        arch_reg_t               arch_reg;
    } rob_out_t;

endpackage : rv32i_types

//--- rtl/free_list.sv
`timescale 1ns/1ps

module free_list (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pop,        // allocation on dispatch
    input  logic                    push,       // release on commit
    input  rename_types::phys_reg_t push_reg,
    output rename_types::phys_reg_t head_reg,
    output logic                    empty
);

    import rename_types::*;

    localparam int PTR_W = $clog2(NUM_FREE_REGS);

    phys_reg_t        mem [NUM_FREE_REGS];
    logic [PTR_W:0]   head;     // msb is the wrap bit
    logic [PTR_W:0]   tail;

    // queue is empty when both pointers match including wrap
    assign empty    = (head == tail);
    assign head_reg = mem[head[PTR_W-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            // full at reset, so tail sits one lap ahead
            tail <= {1'b1, {PTR_W{1'b0}}};
            for (int i = 0; i < NUM_FREE_REGS; i++) begin
                mem[i] <= phys_reg_t'(NUM_ARCH_REGS + i);
            end
        end else begin
            if (pop) begin
                head <= head + 1'b1;
            end
            if (push) begin
                mem[tail[PTR_W-1:0]] <= push_reg;
                tail                 <= tail + 1'b1;
            end
        end
    end

endmodule : free_list

//--- rtl/rat.sv
`timescale 1ns/1ps

module rat (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    dispatch_valid,
    input  rv32i_types::arch_reg_t  dest_arch,
    input  rv32i_types::arch_reg_t  src1_arch,
    input  rv32i_types::arch_reg_t  src2_arch,
    input  logic                    rob_full,
    input  logic                    free_empty,
    input  rename_types::phys_reg_t free_head,
    output logic                    dispatch_fire,
    output rename_types::phys_reg_t alloc_phys,
    output rename_types::phys_reg_t src1_phys,
    output rename_types::phys_reg_t src2_phys
);

    import rename_types::*;

    phys_reg_t map [NUM_ARCH_REGS];   // speculative arch -> phys

    // the one accept decision for the whole subsystem
    // a full rob blocks even if a commit frees a slot this cycle
    assign dispatch_fire = dispatch_valid && !rob_full && !free_empty;

    assign alloc_phys = free_head;

    // lookups see the map before this cycle's write
    assign src1_phys = map[src1_arch];
    assign src2_phys = map[src2_arch];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map[i] <= phys_reg_t'(i);   // identity mapping
            end
        end else if (dispatch_fire) begin
            map[dest_arch] <= free_head;
        end
    end

endmodule : rat

//--- rtl/rob.sv
`timescale 1ns/1ps

module rob #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic                           clk,
    input  logic                           rst,

    // from rename
    input  logic                           enqueue,
    input  rename_types::phys_reg_t        enq_phys,
    input  rv32i_types::arch_reg_t         enq_arch,

    // completion broadcast
    input  logic                           cdb_valid,
    input  logic [$clog2(QUEUE_DEPTH)-1:0] cdb_idx,

    output logic [$clog2(QUEUE_DEPTH)-1:0] tail_idx,
    output logic                           full,

    // to retirement map
    output logic                           commit_valid,
    output rv32i_types::rob_out_t          commit_rec
);

    import rv32i_types::*;

    localparam int IDX_W = $clog2(QUEUE_DEPTH);

    logic [IDX_W:0]   head;     // extra wrap bit
    logic [IDX_W:0]   tail;
    logic [IDX_W-1:0] head_idx;

    logic             entry_valid [QUEUE_DEPTH];
    logic             entry_done  [QUEUE_DEPTH];
    rob_out_t         entry_rec   [QUEUE_DEPTH];

    assign head_idx = head[IDX_W-1:0];
    assign tail_idx = tail[IDX_W-1:0];

    // same slot, different lap
    assign full = (head_idx == tail_idx) && (head[IDX_W] != tail[IDX_W]);

    // retire straight from the head entry
    assign commit_valid = entry_valid[head_idx] && entry_done[head_idx];
    assign commit_rec   = entry_rec[head_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                entry_valid[i] <= 1'b0;
                entry_done[i]  <= 1'b0;
            end
        end else begin
            if (enqueue) begin
                entry_valid[tail_idx] <= 1'b1;
                entry_done[tail_idx]  <= 1'b0;
                tail                  <= tail + 1'b1;
            end

            // cdb names an occupied entry, never the tail slot being filled
            if (cdb_valid) begin
                entry_done[cdb_idx] <= 1'b1;
            end

            if (commit_valid) begin
                entry_valid[head_idx] <= 1'b0;
                head                  <= head + 1'b1;
            end
        end
    end

    // record payload
    always_ff @(posedge clk) begin
        if (enqueue) begin
            entry_rec[tail_idx].phys_reg <= enq_phys;
            entry_rec[tail_idx].arch_reg <= enq_arch;
        end
    end

endmodule : rob

//--- rtl/rrf.sv
`timescale 1ns/1ps

module rrf (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    commit_valid,
    input  rv32i_types::rob_out_t   commit_rec,
    output rename_types::phys_reg_t freed_phys
);

    import rename_types::*;

    phys_reg_t map [NUM_ARCH_REGS];   // committed arch -> phys

    // previous owner of the committing register goes back to the free list
    assign freed_phys = map[commit_rec.arch_reg];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map[i] <= phys_reg_t'(i);
            end
        end else if (commit_valid) begin
            map[commit_rec.arch_reg] <= commit_rec.phys_reg;
        end
    end

endmodule : rrf

//--- rtl/rename_commit_top.sv
`timescale 1ns/1ps

module rename_commit_top #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic                           clk,
    input  logic                           rst,

    // dispatch side
    input  logic                           dispatch_valid,
    input  rv32i_types::arch_reg_t         dest_arch,
    input  rv32i_types::arch_reg_t         src1_arch,
    input  rv32i_types::arch_reg_t         src2_arch,
    output logic                           dispatch_stall,
    output rename_types::phys_reg_t        dispatch_phys,
    output logic [$clog2(QUEUE_DEPTH)-1:0] dispatch_rob_idx,
    output rename_types::phys_reg_t        src1_phys,
    output rename_types::phys_reg_t        src2_phys,

    // completion
    input  logic                           cdb_valid,
    input  logic [$clog2(QUEUE_DEPTH)-1:0] cdb_rob_idx,

    // commit side
    output logic                           commit_valid,
    output rv32i_types::rob_out_t          commit_rec,
    output rename_types::phys_reg_t        freed_phys
);

    import rename_types::*;

    logic      free_empty;
    phys_reg_t free_head;
    logic      dispatch_fire;
    logic      rob_full;

    // valid in the same cycle as the dispatch attempt
    assign dispatch_stall = rob_full || free_empty;

    free_list u_free_list (
        .clk      (clk),
        .rst      (rst),
        .pop      (dispatch_fire),
        .push     (commit_valid),   // freed reg returns on commit
        .push_reg (freed_phys),
        .head_reg (free_head),
        .empty    (free_empty)
    );

    rat u_rat (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dest_arch      (dest_arch),
        .src1_arch      (src1_arch),
        .src2_arch      (src2_arch),
        .rob_full       (rob_full),
        .free_empty     (free_empty),
        .free_head      (free_head),
        .dispatch_fire  (dispatch_fire),
        .alloc_phys     (dispatch_phys),
        .src1_phys      (src1_phys),
        .src2_phys      (src2_phys)
    );

    rob #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_rob (
        .clk          (clk),
        .rst          (rst),
        .enqueue      (dispatch_fire),
        .enq_phys     (dispatch_phys),
        .enq_arch     (dest_arch),
        .cdb_valid    (cdb_valid),
        .cdb_idx      (cdb_rob_idx),
        .tail_idx     (dispatch_rob_idx),
        .full         (rob_full),
        .commit_valid (commit_valid),
        .commit_rec   (commit_rec)
    );

    rrf u_rrf (
        .clk          (clk),
        .rst          (rst),
        .commit_valid (commit_valid),
        .commit_rec   (commit_rec),
        .freed_phys   (freed_phys)
    );

endmodule : rename_commit_top

//--- testbench/rename_commit_assert.sv
`timescale 1ns/1ps

module rename_commit_assert #(
    parameter int QUEUE_DEPTH = 16
) (
    input logic                           clk,
    input logic                           rst,
    input logic                           dispatch_valid,
    input rv32i_types::arch_reg_t         dest_arch,
    input rv32i_types::arch_reg_t         src1_arch,
    input rv32i_types::arch_reg_t         src2_arch,
    input logic                           dispatch_stall,
    input rename_types::phys_reg_t        dispatch_phys,
    input logic [$clog2(QUEUE_DEPTH)-1:0] dispatch_rob_idx,
    input rename_types::phys_reg_t        src1_phys,
    input rename_types::phys_reg_t        src2_phys,
    input logic                           cdb_valid,
    input logic [$clog2(QUEUE_DEPTH)-1:0] cdb_rob_idx,
    input logic                           commit_valid,
    input rv32i_types::rob_out_t          commit_rec,
    input rename_types::phys_reg_t        freed_phys
);

    import rv32i_types::*;
    import rename_types::*;

    localparam int IDX_W = $clog2(QUEUE_DEPTH);

    phys_reg_t        spec_map [NUM_ARCH_REGS];
    phys_reg_t        com_map  [NUM_ARCH_REGS];
    phys_reg_t        free_q   [NUM_PHYS_REGS];   // ring with at most 32 entries in use
    phys_reg_t        dq_phys  [QUEUE_DEPTH];     // accepted dispatches by slot
    arch_reg_t        dq_arch  [QUEUE_DEPTH];
    logic             done     [QUEUE_DEPTH];
    logic             live     [NUM_PHYS_REGS];   // mapped or in flight
    phys_reg_t        free_rd;
    phys_reg_t        free_wr;
    logic [IDX_W-1:0] q_head;
    logic [IDX_W-1:0] q_tail;
    int               q_count;
    int               free_count;

    logic      fire;
    logic      can_commit;
    rob_out_t  oldest;
    phys_reg_t exp_alloc;
    phys_reg_t exp_src1;
    phys_reg_t exp_src2;
    phys_reg_t exp_freed;
    logic      alloc_live;

    // accepted when the shadow rob has room and a register is free
    assign fire       = dispatch_valid && (q_count < QUEUE_DEPTH) && (free_count > 0);
    assign can_commit = (q_count > 0) && done[q_head];
    assign oldest     = {dq_phys[q_head], dq_arch[q_head]};
    assign exp_alloc  = free_q[free_rd];
    assign exp_src1   = spec_map[src1_arch];
    assign exp_src2   = spec_map[src2_arch];
    assign exp_freed  = com_map[oldest.arch_reg];
    assign alloc_live = live[dispatch_phys];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                spec_map[i] <= phys_reg_t'(i);
                com_map[i]  <= phys_reg_t'(i);
            end
            for (int i = 0; i < NUM_PHYS_REGS; i++) begin
                free_q[i] <= phys_reg_t'(NUM_ARCH_REGS + i);
                live[i]   <= (i < NUM_ARCH_REGS);
            end
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                done[i] <= 1'b0;
            end
            free_rd    <= '0;
            free_wr    <= phys_reg_t'(NUM_FREE_REGS);
            q_head     <= '0;
            q_tail     <= '0;
            q_count    <= 0;
            free_count <= NUM_FREE_REGS;
        end else begin
            if (fire) begin
                spec_map[dest_arch] <= free_q[free_rd];
                dq_phys[q_tail]     <= free_q[free_rd];
                dq_arch[q_tail]     <= dest_arch;
                done[q_tail]        <= 1'b0;
                live[free_q[free_rd]] <= 1'b1;
                free_rd             <= free_rd + 1'b1;
                q_tail              <= q_tail + 1'b1;
            end
            if (cdb_valid) begin
                done[cdb_rob_idx] <= 1'b1;
            end
            if (can_commit) begin
                com_map[oldest.arch_reg]       <= oldest.phys_reg;
                live[com_map[oldest.arch_reg]] <= 1'b0;
                free_q[free_wr]                <= com_map[oldest.arch_reg];  // back of the line
                free_wr                        <= free_wr + 1'b1;
                q_head                         <= q_head + 1'b1;
            end
            q_count    <= q_count + int'(fire) - int'(can_commit);
            free_count <= free_count - int'(fire) + int'(can_commit);
        end
    end

    a_alloc: assert property (@(posedge clk) disable iff (rst)
        fire |-> dispatch_phys == exp_alloc && dispatch_rob_idx == q_tail)
        else begin
            $error("ERROR %0t: dispatch got phys %0d slot %0d", $time,
                   $sampled(dispatch_phys), $sampled(dispatch_rob_idx));
            tb_rename_commit.fail_count++;
        end

    a_sources: assert property (@(posedge clk) disable iff (rst)
        src1_phys == exp_src1 && src2_phys == exp_src2)
        else begin
            $error("ERROR %0t: source lookup %0d/%0d", $time,
                   $sampled(src1_phys), $sampled(src2_phys));
            tb_rename_commit.fail_count++;
        end

    a_stall: assert property (@(posedge clk) disable iff (rst)
        dispatch_stall == (q_count == QUEUE_DEPTH || free_count == 0))
        else begin
            $error("ERROR %0t: dispatch_stall is %0b", $time, $sampled(dispatch_stall));
            tb_rename_commit.fail_count++;
        end

    // head commits as soon as it is done and never earlier
    a_commit_when_done: assert property (@(posedge clk) disable iff (rst)
        commit_valid == can_commit)
        else begin
            $error("ERROR %0t: commit_valid is %0b", $time, $sampled(commit_valid));
            tb_rename_commit.fail_count++;
        end

    a_commit: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_rec == oldest && freed_phys == exp_freed)
        else begin
            $error("ERROR %0t: commit arch %0d phys %0d freed %0d", $time,
                   $sampled(commit_rec.arch_reg), $sampled(commit_rec.phys_reg),
                   $sampled(freed_phys));
            tb_rename_commit.fail_count++;
        end

    a_unique: assert property (@(posedge clk) disable iff (rst)
        fire |-> !alloc_live)
        else begin
            $error("ERROR %0t: phys %0d allocated while live", $time, $sampled(dispatch_phys));
            tb_rename_commit.fail_count++;
        end

endmodule : rename_commit_assert

//--- testbench/tb_rename_commit.sv
`timescale 1ns/1ps

module tb_rename_commit;

    import rv32i_types::*;
    import rename_types::*;

    localparam int QUEUE_DEPTH = 16;
    localparam int IDX_W       = $clog2(QUEUE_DEPTH);
    localparam int TIMEOUT     = 2000;   // about 4x what the tests need

    logic             clk;
    logic             rst;
    logic             dispatch_valid;
    arch_reg_t        dest_arch;
    arch_reg_t        src1_arch;
    arch_reg_t        src2_arch;
    logic             dispatch_stall;
    phys_reg_t        dispatch_phys;
    logic [IDX_W-1:0] dispatch_rob_idx;
    phys_reg_t        src1_phys;
    phys_reg_t        src2_phys;
    logic             cdb_valid;
    logic [IDX_W-1:0] cdb_rob_idx;
    logic             commit_valid;
    rob_out_t         commit_rec;
    phys_reg_t        freed_phys;

    int   fail_count  = 0;   // bumped by the bound assertions
    int   cycles      = 0;
    int   tests_run   = 0;
    int   outstanding = 0;   // dispatched, not yet committed
    int   wraps       = 0;   // times phys 63 was handed out
    logic held;              // last dispatch was stalled

    logic [IDX_W-1:0] pending [$];   // slots still waiting for the cdb

    rename_commit_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) uut (.*);

    bind rename_commit_top rename_commit_assert #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_assert (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: the run did not end within %0d cycles", TIMEOUT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // one clock: drive at the rising edge, look at the outputs mid cycle
    task automatic step(input logic dv, input logic cv, input logic [IDX_W-1:0] ci,
                        output logic accepted);
        @(posedge clk);
        if (!held) begin   // a stalled op keeps its operands
            dest_arch <= arch_reg_t'($urandom);
            src1_arch <= arch_reg_t'($urandom);
            src2_arch <= arch_reg_t'($urandom);
        end
        dispatch_valid <= dv;
        cdb_valid      <= cv;
        cdb_rob_idx    <= ci;
        @(negedge clk);
        accepted = dv && !dispatch_stall;
        held     = dv && dispatch_stall;
        if (accepted) begin
            pending.push_back(dispatch_rob_idx);
            outstanding++;
            if (dispatch_phys == phys_reg_t'(NUM_PHYS_REGS - 1)) begin
                wraps++;
            end
        end
        if (commit_valid) begin
            outstanding--;
        end
    endtask

    // random pending slot, taken with probability pct percent
    task automatic pick_completion(input int pct, output logic cv,
                                   output logic [IDX_W-1:0] ci);
        int k;
        cv = 1'b0;
        ci = '0;
        if (pending.size() > 0 && int'($urandom_range(99)) < pct) begin
            k  = $urandom_range(pending.size() - 1);
            cv = 1'b1;
            ci = pending[k];
            pending.delete(k);
        end
    endtask

    task automatic run_mix(input int n_disp, input int pct);
        int               sent;
        logic             cv;
        logic             acc;
        logic [IDX_W-1:0] ci;
        sent = 0;
        while (sent < n_disp) begin
            pick_completion(pct, cv, ci);
            step(1'b1, cv, ci, acc);
            if (acc) begin
                sent++;
            end
        end
    endtask

    task automatic drain();   // complete everything, wait for the last commit
        logic             cv;
        logic             acc;
        logic [IDX_W-1:0] ci;
        while (outstanding > 0) begin
            pick_completion(100, cv, ci);
            step(1'b0, cv, ci, acc);
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        tests_run++;
        $display("test %0d %s done: %0d assertion failures", tests_run, name,
                 fail_count - fails_before);
    endtask

    initial begin
        int               fails_before;
        logic             acc;
        logic [IDX_W-1:0] ci;
        void'($urandom(32'h6556_6c16));
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dest_arch      = '0;
        src1_arch      = '0;
        src2_arch      = '0;
        cdb_valid      = 1'b0;
        cdb_rob_idx    = '0;
        held           = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        fails_before = fail_count;
        repeat (4) step(1'b0, 1'b0, '0, acc);   // identity lookups
        step(1'b1, 1'b0, '0, acc);              // expect phys 32 in slot 0
        drain();
        report_test("reset state", fails_before);

        fails_before = fail_count;
        run_mix(20, 40);
        drain();
        report_test("allocation", fails_before);

        fails_before = fail_count;
        run_mix(12, 0);
        drain();   // random completion order
        report_test("in-order commit", fails_before);

        fails_before = fail_count;
        run_mix(30, 70);
        drain();
        report_test("freeing", fails_before);

        fails_before = fail_count;
        run_mix(QUEUE_DEPTH, 0);
        repeat (4) step(1'b1, 1'b0, '0, acc);   // held while full
        ci = pending.pop_front();
        step(1'b1, 1'b1, ci, acc);
        while (!acc) begin
            step(1'b1, 1'b0, '0, acc);
        end
        drain();
        report_test("full rob", fails_before);

        fails_before = fail_count;
        wraps = 0;
        while (wraps < 2) begin
            run_mix(1, 60);
        end
        drain();
        report_test("free list wrap", fails_before);

        step(1'b0, 1'b0, '0, acc);
        $display("summary: %0d tests run, %0d assertion failures", tests_run, fail_count);
        if (fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_rename_commit

//--- project.f
rtl/rename_types.sv
rtl/rv32i_types.sv
rtl/free_list.sv
rtl/rat.sv
rtl/rob.sv
rtl/rrf.sv
rtl/rename_commit_top.sv
testbench/rename_commit_assert.sv
testbench/tb_rename_commit.sv
